/* list.f */
sifhTypesPkg.sv
sifhCtrlPkg.sv
sifhBus.sv
frameSequencer.sv
sampleFilter.sv
binHistogram.sv
peakTracker.sv
windowCalc.sv
sifhTop.sv
tbSifh.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbSifh
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tbSifh.sv */
// testbench of the two-pass peak finder
// sends whole frames of coarse and fine samples, predicts every pixel result
// and checks each resultValid pulse against that prediction
`default_nettype none

module tbSifh import sifhTypesPkg::*; ();

    localparam int PIXEL_NUM         = 4;
    localparam int SAMPLES_PER_PIXEL = 3;
    localparam int ACQ_NUM           = 8;
    localparam int PERIOD            = 20;
    localparam int STROBES           = PIXEL_NUM * SAMPLES_PER_PIXEL * ACQ_NUM;
    localparam int PASS_GAP          = 6;
    localparam int MAX_GAP           = 3;
    localparam int FRAME_COUNT       = 10;
    // every strobe at its widest spacing, the pass gaps and the resets
    localparam int LIMIT_CYCLES =
        FRAME_COUNT * 2 * (STROBES * (MAX_GAP + 1) + PASS_GAP + 1) + 100;

    localparam int TS_SPAN   = 2 ** TS_W;
    localparam int SPAN      = 2 ** BIN_W;
    localparam int HALF      = SPAN / 2;
    localparam int LOW_MAX   = TS_SPAN - SPAN;
    localparam int SHIFT     = TS_W - BIN_W;
    localparam int COUNT_MAX = (2 ** COUNT_W) - 1;

    logic                      clk;
    logic                      combin_res;
    logic                      wrEn;
    ts_t                       data;
    logic [PIXEL_NUM*TS_W-1:0] result;
    logic                      resultValid;

    // samples of the frame in arrival order
    ts_t coarseTs [STROBES];
    ts_t fineTs   [STROBES];
    int  centreC  [PIXEL_NUM];
    int  centreF  [PIXEL_NUM];
    ts_t expectQ  [$];
    int  framesSent;
    int  framesChecked;

    sifhTop #(
        .PIXEL_NUM(PIXEL_NUM),
        .SAMPLES_PER_PIXEL(SAMPLES_PER_PIXEL),
        .ACQ_NUM(ACQ_NUM)
    ) uut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .result(result), .resultValid(resultValid)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // ************************************************************
    // reference model
    // ************************************************************

    // sample -> pixel -> acquisition order
    function automatic int pixelOf(input int k);
        return (k / SAMPLES_PER_PIXEL) % PIXEL_NUM;
    endfunction

    function automatic ts_t clampTs(input int v);
        int c;
        c = v;
        if (c < 0) begin
            c = 0;
        end
        if (c > TS_SPAN - 1) begin
            c = TS_SPAN - 1;
        end
        return ts_t'(c);
    endfunction

    function automatic int jitter(input int s);
        return int'($urandom % 32'(2 * s + 1)) - s;
    endfunction

    // coarse peak, window, then fine peak above the window low edge
    function automatic ts_t refResult(input int pix);
        int hist [SPAN];
        int best;
        int bestBin;
        int bin;
        int low;
        best    = 0;
        bestBin = 0;
        for (int b = 0; b < SPAN; b++) begin
            hist[b] = 0;
        end
        for (int k = 0; k < STROBES; k++) begin
            if (pixelOf(k) == pix) begin
                bin = int'(coarseTs[k]) >> SHIFT;
                if (hist[bin] < COUNT_MAX) begin
                    hist[bin]++;
                end
                // ties keep the bin that got there first
                if (hist[bin] > best) begin
                    best    = hist[bin];
                    bestBin = bin;
                end
            end
        end
        low = (bestBin << SHIFT) - HALF;
        if (low < 0) begin
            low = 0;
        end
        if (low > LOW_MAX) begin
            low = LOW_MAX;
        end
        // fine pass starts from scratch
        best    = 0;
        bestBin = 0;
        for (int b = 0; b < SPAN; b++) begin
            hist[b] = 0;
        end
        for (int k = 0; k < STROBES; k++) begin
            if (pixelOf(k) == pix && int'(fineTs[k]) >= low
                    && int'(fineTs[k]) <= low + SPAN - 1) begin
                bin = int'(fineTs[k]) - low;
                if (hist[bin] < COUNT_MAX) begin
                    hist[bin]++;
                end
                if (hist[bin] > best) begin
                    best    = hist[bin];
                    bestBin = bin;
                end
            end
        end
        // empty window gives bin zero
        return ts_t'(low + bestBin);
    endfunction

    // ************************************************************
    // stimulus helpers
    // ************************************************************
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // far fine centres put every fine sample outside its window
    task automatic randomCentres(input bit farFine);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            centreC[p] = int'($urandom % 32'(TS_SPAN));
            centreF[p] = farFine ? (centreC[p] + TS_SPAN / 2) % TS_SPAN : centreC[p];
        end
    endtask

    task automatic fillCluster(input int spreadW);
        for (int k = 0; k < STROBES; k++) begin
            coarseTs[k] = clampTs(centreC[pixelOf(k)] + jitter(spreadW));
            fineTs[k]   = clampTs(centreF[pixelOf(k)] + jitter(spreadW));
        end
    endtask

    // one strobe per cycle, or random idle cycles in between
    task automatic sendPass(input bit isFine, input int maxGap, input int count);
        int gap;
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            #2;
            wrEn = 1'b1;
            data = isFine ? fineTs[k] : coarseTs[k];
            gap  = (maxGap > 0) ? int'($urandom % 32'(maxGap + 1)) : 0;
            repeat (gap) begin
                @(posedge clk);
                #2;
                wrEn = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        wrEn = 1'b0;
    endtask

    task automatic sendFrame(input int maxGap);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expectQ.push_back(refResult(p));
        end
        framesSent++;
        sendPass(1'b0, maxGap, STROBES);
        // idle gap the host owes between passes
        repeat (PASS_GAP) @(posedge clk);
        sendPass(1'b1, maxGap, STROBES);
        repeat (PASS_GAP) @(posedge clk);
    endtask

    task automatic applyReset();
        @(posedge clk);
        #2;
        combin_res = 1'b0;
        wrEn       = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        combin_res = 1'b1;
    endtask

    // ************************************************************
    // checker and watchdog
    // ************************************************************
    initial begin : compare
        ts_t want;
        ts_t got;
        forever begin
            @(negedge clk);
            if (resultValid === 1'b1) begin
                if (expectQ.size() < PIXEL_NUM) begin
                    $display("resultValid pulsed while no frame was outstanding");
                    $display("Simulation failed");
                    $fatal(1, "unexpected result");
                end else begin
                    for (int p = 0; p < PIXEL_NUM; p++) begin
                        want = expectQ.pop_front();
                        got  = result[p*TS_W +: TS_W];
                        checkValue($sformatf("result[%0d]", p), 32'(want), 32'(got));
                    end
                    framesChecked++;
                end
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * 2 * PERIOD);
        $display("Watchdog expired before all frames were checked");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        combin_res    = 1'b0;
        wrEn          = 1'b0;
        data          = '0;
        framesSent    = 0;
        framesChecked = 0;
        void'($urandom(32'h6c6f_08b1));
        applyReset();

        // clustered samples, dense then sparse
        randomCentres(1'b0);
        fillCluster(12);
        sendFrame(0);
        randomCentres(1'b0);
        fillCluster(12);
        sendFrame(MAX_GAP);

        // both window clamps
        centreC = '{5, 1019, 40, 990};
        centreF = '{5, 1019, 40, 990};
        fillCluster(8);
        sendFrame(0);

        // fine samples miss every window
        randomCentres(1'b1);
        fillCluster(10);
        sendFrame(MAX_GAP);

        // one bin per pixel, back to back then sparse
        randomCentres(1'b0);
        fillCluster(0);
        sendFrame(0);
        sendFrame(MAX_GAP);

        // consecutive frames
        randomCentres(1'b0);
        fillCluster(12);
        sendFrame(0);
        randomCentres(1'b0);
        fillCluster(20);
        sendFrame(1);

        // reset while the end of a fine pass is still in the pipeline
        randomCentres(1'b0);
        fillCluster(12);
        sendPass(1'b0, 0, STROBES);
        repeat (PASS_GAP) @(posedge clk);
        sendPass(1'b1, 0, STROBES);
        applyReset();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            checkValue("resultValid", 32'h0, 32'(resultValid));
        end
        sendFrame(0);

        wait (framesChecked == framesSent);
        // room for a stray second pulse
        repeat (5) @(posedge clk);
        if (expectQ.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Some expected results were never produced");
            $display("Simulation failed");
            $fatal(1, "missing results");
        end
    end

endmodule

`default_nettype wire

/* sifhTop.sv */
// top level of the two-pass peak finder
// one timestamp per wrEn strobe in, all pixel peaks out with a resultValid pulse
`default_nettype none

module sifhTop import sifhTypesPkg::*, sifhCtrlPkg::*; #(
    parameter int PIXEL_NUM         = 4,
    parameter int SAMPLES_PER_PIXEL = 3,
    parameter int ACQ_NUM           = 8
) (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      wrEn,
    input  ts_t                       data,
    output logic [PIXEL_NUM*TS_W-1:0] result,
    output logic                      resultValid
);

    localparam int PIX_W = $clog2(PIXEL_NUM);

    logic [PIX_W-1:0] pixelIdx;
    passKind_e        pass;
    logic             passDone;
    count_t           count;
    bin_t             cntBin;
    logic [PIX_W-1:0] cntPixel;
    logic             cntValid;
    bin_t             peakBins [PIXEL_NUM];
    ts_t              results [PIXEL_NUM];

    sampleBus_if #(.PIXEL_NUM(PIXEL_NUM)) sampleBus ();
    windowBus_if #(.PIXEL_NUM(PIXEL_NUM)) windowBus ();

    // ****************************************************************
    // control and pipeline
    // ****************************************************************
    frameSequencer #(
        .PIXEL_NUM(PIXEL_NUM),
        .SAMPLES_PER_PIXEL(SAMPLES_PER_PIXEL),
        .ACQ_NUM(ACQ_NUM)
    ) sequencer (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn),
        .pixelIdx(pixelIdx), .pass(pass), .passDone(passDone)
    );

    sampleFilter #(.PIXEL_NUM(PIXEL_NUM)) filter (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .pixelIdx(pixelIdx), .pass(pass), .bus(sampleBus.filt), .win(windowBus.filt)
    );

    binHistogram #(.PIXEL_NUM(PIXEL_NUM)) histogram (
        .clk(clk), .combin_res(combin_res), .passDone(passDone), .bus(sampleBus.hist),
        .count(count), .cntBin(cntBin), .cntPixel(cntPixel), .cntValid(cntValid)
    );

    peakTracker #(.PIXEL_NUM(PIXEL_NUM)) peaks (
        .clk(clk), .combin_res(combin_res), .passDone(passDone), .count(count),
        .cntBin(cntBin), .cntPixel(cntPixel), .cntValid(cntValid), .peakBins(peakBins)
    );

    windowCalc #(.PIXEL_NUM(PIXEL_NUM)) calc (
        .clk(clk), .combin_res(combin_res), .passDone(passDone), .pass(pass),
        .peakBins(peakBins), .win(windowBus.calc), .results(results),
        .resultValid(resultValid)
    );

    // pixel 0 in the low bits
    for (genvar p = 0; p < PIXEL_NUM; p++) begin : g_flat
        assign result[p*TS_W +: TS_W] = results[p];
    end

endmodule

`default_nettype wire

/* windowCalc.sv */
// fine windows from the coarse peaks, final results from the fine peaks
// serves window edges to the filter and pulses resultValid once per frame
`default_nettype none

module windowCalc import sifhTypesPkg::*, sifhCtrlPkg::*; #(
    parameter int PIXEL_NUM = 4
) (
    input  logic      clk,
    input  logic      combin_res,
    input  logic      passDone,
    input  passKind_e pass,
    input  bin_t      peakBins [PIXEL_NUM],
    windowBus_if.calc win,
    output ts_t       results [PIXEL_NUM],
    output logic      resultValid
);

    // half window and the highest legal low edge
    localparam int SPAN    = 2 ** BIN_W;
    localparam int SB      = SPAN / 2;
    localparam int LOW_MAX = (2 ** TS_W) - SPAN;

    ts_t winLowReg [PIXEL_NUM];

    // coarse bin back to a timestamp, then centred and clamped
    function automatic ts_t lowEdge(input bin_t peak);
        int centre;
        int low;
        centre = int'(peak) << (TS_W - BIN_W);
        low    = centre - SB;
        if (low < 0) begin
            low = 0;
        end
        if (low > LOW_MAX) begin
            low = LOW_MAX;
        end
        return ts_t'(low);
    endfunction

    assign win.winLow  = winLowReg[win.rdPixel];
    assign win.winHigh = win.winLow + ts_t'(SPAN - 1);

    // pass has already flipped when passDone arrives
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            win.winReady <= 1'b0;
            resultValid  <= 1'b0;
        end else begin
            resultValid <= passDone && (pass == PASS_COARSE);
            if (passDone) begin
                // windows live for the fine pass only
                win.winReady <= (pass == PASS_FINE);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < PIXEL_NUM; i++) begin
            if (passDone && (pass == PASS_FINE)) begin
                winLowReg[i] <= lowEdge(peakBins[i]);
            end
            // empty fine window leaves bin zero, i.e. the low edge
            if (passDone && (pass == PASS_COARSE)) begin
                results[i] <= winLowReg[i] + ts_t'(peakBins[i]);
            end
        end
    end

    a_winOrder: assert property (
        @(posedge clk) disable iff (!combin_res) win.winReady |-> win.winHigh >= win.winLow
    );

endmodule

`default_nettype wire

/* peakTracker.sv */
// running maximum of the bin counts, third pipeline stage
// keeps the fullest bin of each pixel for the window and result logic
`default_nettype none

module peakTracker import sifhTypesPkg::*; #(
    parameter int PIXEL_NUM = 4
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         passDone,
    input  count_t                       count,
    input  bin_t                         cntBin,
    input  logic [$clog2(PIXEL_NUM)-1:0] cntPixel,
    input  logic                         cntValid,
    output bin_t                         peakBins [PIXEL_NUM]
);

    count_t maxCount [PIXEL_NUM];
    logic   isHigher;

    // strictly greater, so ties stay with the first bin to get there
    assign isHigher = count > maxCount[cntPixel];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXEL_NUM; i++) begin
                maxCount[i] <= '0;
                peakBins[i] <= '0;
            end
        end else if (passDone) begin
            // fresh start for the next pass
            for (int i = 0; i < PIXEL_NUM; i++) begin
                maxCount[i] <= '0;
                peakBins[i] <= '0;
            end
        end else if (cntValid && isHigher) begin
            maxCount[cntPixel] <= count;
            peakBins[cntPixel] <= cntBin;
        end
    end

endmodule

`default_nettype wire

/* binHistogram.sv */
// per-pixel bin counters, second pipeline stage
// a clear valid bit reads as zero, so passDone empties a pass in one cycle
`default_nettype none

module binHistogram import sifhTypesPkg::*; #(
    parameter int PIXEL_NUM = 4
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         passDone,
    sampleBus_if.hist                    bus,
    output count_t                       count,
    output bin_t                         cntBin,
    output logic [$clog2(PIXEL_NUM)-1:0] cntPixel,
    output logic                         cntValid
);

    localparam int PIX_W  = $clog2(PIXEL_NUM);
    localparam int ADDR_W = PIX_W + BIN_W;
    localparam int DEPTH  = PIXEL_NUM * (2 ** BIN_W);

    // ****************************************************************
    // counter storage
    // ****************************************************************
    count_t            mem [DEPTH];
    logic [DEPTH-1:0]  binUsed;
    logic [ADDR_W-1:0] addr;
    count_t            stored;
    count_t            current;
    count_t            nextCount;
    logic              hitLast;

    // pixel picks the 64-bin slice
    assign addr = {bus.pixelIdx, bus.binAddr};

    // never-touched bin counts from zero
    assign stored = binUsed[addr] ? mem[addr] : '0;

    // same pixel and bin as the sample just written
    assign hitLast = cntValid && (cntPixel == bus.pixelIdx) && (cntBin == bus.binAddr);
    assign current = hitLast ? count : stored;

    // saturate at the top of the counter
    assign nextCount = (current == '1) ? current : count_t'(current + 1'b1);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binUsed  <= '0;
            cntValid <= 1'b0;
        end else begin
            cntValid <= bus.binValid;
            if (passDone) begin
                binUsed <= '0;
            end else if (bus.binValid) begin
                binUsed[addr] <= 1'b1;
            end
        end
    end

    // write-back and hand-off to the peak tracker
    always_ff @(posedge clk) begin
        if (bus.binValid) begin
            mem[addr] <= nextCount;
        end
        count    <= nextCount;
        cntBin   <= bus.binAddr;
        cntPixel <= bus.pixelIdx;
    end

    // back-to-back samples always belong to one pass
    a_passSteady: assert property (
        @(posedge clk) disable iff (!combin_res)
        bus.binValid && $past(bus.binValid) |-> bus.pass == $past(bus.pass)
    );

endmodule

`default_nettype wire

/* sampleFilter.sv */
// first pipeline stage, raw timestamp to bin address
// coarse pass takes the upper bits, fine pass the offset inside the window
`default_nettype none

module sampleFilter import sifhTypesPkg::*, sifhCtrlPkg::*; #(
    parameter int PIXEL_NUM = 4
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         wrEn,
    input  ts_t                          data,
    input  logic [$clog2(PIXEL_NUM)-1:0] pixelIdx,
    input  passKind_e                    pass,
    sampleBus_if.filt                    bus,
    windowBus_if.filt                    win
);

    tsWord_u word;
    ts_t     offset;
    logic    inWindow;

    assign word = data;

    // window of the strobe's own pixel
    assign win.rdPixel = pixelIdx;

    // inclusive on both edges
    assign inWindow = win.winReady && (word.raw >= win.winLow) && (word.raw <= win.winHigh);
    assign offset   = word.raw - win.winLow;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bus.binValid <= 1'b0;
        end else begin
            // samples outside the window never reach the histogram
            bus.binValid <= wrEn && ((pass == PASS_COARSE) || inWindow);
        end
    end

    always_ff @(posedge clk) begin
        bus.binAddr  <= (pass == PASS_COARSE) ? word.coarse.coarseBin : offset[BIN_W-1:0];
        bus.pixelIdx <= pixelIdx;
        bus.pass     <= pass;
    end

    // fine strobes arrive only after the coarse windows are latched
    a_fineNeedsWin: assert property (
        @(posedge clk) disable iff (!combin_res)
        wrEn && (pass == PASS_FINE) |-> win.winReady
    );

endmodule

`default_nettype wire

/* frameSequencer.sv */
// sample, pixel and acquisition counters of a frame
// tells each strobe its pixel and pass, pulses passDone once the pipeline drains
`default_nettype none

module frameSequencer import sifhCtrlPkg::*; #(
    parameter int PIXEL_NUM         = 4,
    parameter int SAMPLES_PER_PIXEL = 3,
    parameter int ACQ_NUM           = 8
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         wrEn,
    output logic [$clog2(PIXEL_NUM)-1:0] pixelIdx,
    output passKind_e                    pass,
    output logic                         passDone
);

    localparam int PIX_W = $clog2(PIXEL_NUM);
    localparam int SMP_W = $clog2(SAMPLES_PER_PIXEL);
    localparam int ACQ_W = $clog2(ACQ_NUM);

    logic [SMP_W-1:0]      sampleCnt;
    logic [PIX_W-1:0]      pixelCnt;
    logic [ACQ_W-1:0]      acqCnt;
    logic                  lastSample;
    logic                  lastPixel;
    logic                  lastAcq;
    logic                  endOfPass;
    logic [PIPE_DEPTH:0]   endPipe;

    // wrap points of the nested counters
    assign lastSample = (sampleCnt == SMP_W'(SAMPLES_PER_PIXEL - 1));
    assign lastPixel  = (pixelCnt == PIX_W'(PIXEL_NUM - 1));
    assign lastAcq    = (acqCnt == ACQ_W'(ACQ_NUM - 1));
    assign endOfPass  = lastSample && lastPixel && lastAcq;

    // counters hold the position of the strobe now on the input
    assign pixelIdx = pixelCnt;

    // end marker reaches the top bit as the last sample updates the peaks
    assign passDone = endPipe[PIPE_DEPTH];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            pass      <= PASS_COARSE;
            endPipe   <= '0;
        end else begin
            endPipe <= {endPipe[PIPE_DEPTH-1:0], wrEn && endOfPass};
            if (wrEn) begin
                // sample -> pixel -> acquisition
                sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
                if (lastSample) begin
                    pixelCnt <= lastPixel ? '0 : pixelCnt + 1'b1;
                    if (lastPixel) begin
                        acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                    end
                end
                // coarse and fine alternate, one frame is two passes
                if (endOfPass) begin
                    pass <= (pass == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                end
            end
        end
    end

    // host keeps its idle gap, so no strobe meets the pass boundary
    a_doneIdle: assert property (
        @(posedge clk) disable iff (!combin_res) passDone |-> !wrEn
    );

endmodule

`default_nettype wire

/* sifhBus.sv */
// interfaces between the blocks of the peak finder
// sampleBus_if carries filtered samples, windowBus_if looks up fine windows
`default_nettype none

// filtered sample, one per cycle while binValid is high
interface sampleBus_if import sifhTypesPkg::*, sifhCtrlPkg::*; #(
    parameter int PIXEL_NUM = 4
) ();
    logic                         binValid;
    bin_t                         binAddr;
    logic [$clog2(PIXEL_NUM)-1:0] pixelIdx;
    passKind_e                    pass;

    modport filt (output binValid, binAddr, pixelIdx, pass);
    modport hist (input binValid, binAddr, pixelIdx, pass);
endinterface

// window lookup, edges come back combinationally for rdPixel
interface windowBus_if import sifhTypesPkg::*; #(
    parameter int PIXEL_NUM = 4
) ();
    logic [$clog2(PIXEL_NUM)-1:0] rdPixel;
    ts_t                          winLow;
    ts_t                          winHigh;
    logic                         winReady;

    modport filt (output rdPixel, input winLow, winHigh, winReady);
    modport calc (input rdPixel, output winLow, winHigh, winReady);
endinterface

`default_nettype wire

/* sifhCtrlPkg.sv */
// control definitions of the peak finder
// pass kind and the strobe-to-peak pipeline depth
`default_nettype none

package sifhCtrlPkg;

    // which histogram pass a sample belongs to
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } passKind_e;

    // filter, histogram and peak stages
    localparam int PIPE_DEPTH = 3;

endpackage

`default_nettype wire

/* sifhTypesPkg.sv */
// datapath widths and timestamp types of the two-pass peak finder
// imported by every block that handles timestamps, bins or counts
`default_nettype none

package sifhTypesPkg;

    // timestamp, bin address and bin counter widths
    localparam int TS_W    = 10;
    localparam int BIN_W   = 6;
    localparam int COUNT_W = 8;

    // leftover timestamp bits below the coarse bin
    localparam int FINE_W  = TS_W - BIN_W;

    typedef logic [TS_W-1:0]    ts_t;
    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [COUNT_W-1:0] count_t;

    // coarse view, upper bits pick the bin
    typedef struct packed {
        bin_t              coarseBin;
        logic [FINE_W-1:0] fine;
    } tsCoarse_t;

    // one timestamp word, read raw in the fine pass and split in the coarse pass
    typedef union packed {
        ts_t       raw;
        tsCoarse_t coarse;
    } tsWord_u;

endpackage

`default_nettype wire
